/* Makefile */
# Verilator build and run of the convolution accelerator testbench

VERILATOR ?= verilator
TOP       ?= conv_accel_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= *** TEST FAILED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/conv_accel_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accel_asserts (
   input logic clk_i,
   input logic rst_i,
   input logic hold_i,
   input logic stall_i,
   input logic result_valid_i
);

   int fail_count = 0;

   // the core either waits or takes a result, never both
   handshake_excl: assert property (@(posedge clk_i) disable iff (!rst_i)
      !(stall_i && result_valid_i))
      else begin
         $error("stall and result valid high in the same cycle");
         fail_count = fail_count + 1;
      end

   quiet_on_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
      hold_i |-> (!stall_i && !result_valid_i))
      else begin
         $error("handshake output high while the core holds");
         fail_count = fail_count + 1;
      end

   idle_after_reset: assert property (@(posedge clk_i)
      !rst_i |=> (!stall_i && !result_valid_i))
      else begin
         $error("handshake output high in the cycle after reset");
         fail_count = fail_count + 1;
      end

endmodule

bind conv_ctrl conv_accel_asserts asserts_i (
   .clk_i          (clk_i),
   .rst_i          (rst_i),
   .hold_i         (hold_i),
   .stall_i        (stall_o),
   .result_valid_i (result_valid_o)
);

`default_nettype wire

/* bench/conv_accel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accel_tb;
   import conv_pkg::*;

   localparam int PERIOD      = 100;
   localparam int SAMPLE_DLY  = 10;   // after the falling edge, outputs settled
   localparam int NUM_CASES   = 6;
   localparam int CYCLE_LIMIT = NUM_CASES * 120 + 100;

   localparam logic [1:0] STYLE_PAIR   = 2'd0;
   localparam logic [1:0] STYLE_SINGLE = 2'd1;
   localparam logic [1:0] STYLE_MIXED  = 2'd2;   // filter in pairs, data single

   typedef struct packed {
      logic [1:0] style;
      logic       run_early;   // run raised before loading
      logic [7:0] hold_at;     // cycles after run rises
      logic [7:0] hold_len;    // 0 means no hold
      logic [1:0] clr;         // bit 0 filter, bit 1 data
      logic       late_wr;     // writes after done, then a second run
   } case_t;

   case_t cases [NUM_CASES] = '{
      '{STYLE_PAIR,   1'b0, 8'd0, 8'd0, 2'b11, 1'b0},
      '{STYLE_SINGLE, 1'b1, 8'd0, 8'd0, 2'b11, 1'b0},
      '{STYLE_MIXED,  1'b0, 8'd1, 8'd6, 2'b11, 1'b0},
      '{STYLE_PAIR,   1'b0, 8'd0, 8'd0, 2'b10, 1'b0},   // new data, old filter
      '{STYLE_SINGLE, 1'b1, 8'd0, 8'd4, 2'b10, 1'b1},
      '{STYLE_MIXED,  1'b1, 8'd2, 8'd3, 2'b10, 1'b1}    // filter kept past the late writes
   };

   logic  clk_i;
   logic  rst_i;
   logic  hold_i;
   logic  filter_wr1_i, filter_wr2_i, filter_clr_i;
   logic  data_wr1_i, data_wr2_i, data_clr_i;
   logic  conv_run_i;
   word_t rs1_i, rs2_i;
   word_t result_o;
   logic  result_valid_o, stall_o;

   word_t filt [ELEM_COUNT];   // bank contents as the core wrote them
   word_t dat  [ELEM_COUNT];
   int    seed   = 74;
   int    cycles = 0;

   conv_accel dut_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .hold_i         (hold_i),
      .filter_wr1_i   (filter_wr1_i),
      .filter_wr2_i   (filter_wr2_i),
      .filter_clr_i   (filter_clr_i),
      .data_wr1_i     (data_wr1_i),
      .data_wr2_i     (data_wr2_i),
      .data_clr_i     (data_clr_i),
      .conv_run_i     (conv_run_i),
      .rs1_i          (rs1_i),
      .rs2_i          (rs2_i),
      .result_o       (result_o),
      .result_valid_o (result_valid_o),
      .stall_o        (stall_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(PERIOD / 2) clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (dut_i.ctrl_i.asserts_i.fail_count != 0) begin
         $display("a handshake assertion failed, see the error above");
         $display("*** TEST FAILED ***");
         $fatal(1, "stopping at the first error");
      end else if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: no final result after %0d clock cycles", cycles);
         $display("*** TEST FAILED ***");
         $fatal(1, "simulation stopped by the cycle limit");
      end
   end

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "stopping at the first error");
      end
   endtask

   // modulo 2^32 dot product over the first n entries
   function automatic word_t partial_sum(input int n);
      word_t acc;
      acc = '0;
      for (int i = 0; i < n; i++) begin
         acc = acc + filt[i] * dat[i];
      end
      return acc;
   endfunction

   task automatic next_cycle(input logic run, input logic hold);
      @(negedge clk_i);
      filter_wr1_i = 1'b0;
      filter_wr2_i = 1'b0;
      filter_clr_i = 1'b0;
      data_wr1_i   = 1'b0;
      data_wr2_i   = 1'b0;
      data_clr_i   = 1'b0;
      conv_run_i   = run;
      hold_i       = hold;
   endtask

   task automatic load_banks(input logic [1:0] style, input logic run,
                             input logic do_filt, input logic do_data);
      int    nf;
      int    nd;
      int    n;
      int    prev_min;
      int    cur_min;
      logic  turn_f;
      word_t w1;
      word_t w2;
      nf       = do_filt ? 0 : ELEM_COUNT;
      nd       = do_data ? 0 : ELEM_COUNT;
      prev_min = (nf < nd) ? nf : nd;
      turn_f   = do_filt;
      while (nf < ELEM_COUNT || nd < ELEM_COUNT) begin
         if (nf == ELEM_COUNT)
            turn_f = 1'b0;
         else if (nd == ELEM_COUNT)
            turn_f = 1'b1;
         n  = (turn_f ? (style != STYLE_SINGLE) : (style == STYLE_PAIR)) ? 2 : 1;
         w1 = $random(seed);
         w2 = $random(seed);
         next_cycle(run, 1'b0);
         filter_wr1_i = turn_f && (n == 1);
         filter_wr2_i = turn_f && (n == 2);
         data_wr1_i   = !turn_f && (n == 1);
         data_wr2_i   = !turn_f && (n == 2);
         rs1_i        = w1;
         rs2_i        = w2;
         #SAMPLE_DLY;
         if (run) begin
            cur_min = (nf < nd) ? nf : nd;
            if (cur_min > prev_min)   // pair completed at the last edge, not summed yet
               check_flag(stall_o, 1'b1, "stall with a new pair pending");
            if (result_valid_o)   // nothing pending means every present pair is summed
               check_word(result_o, partial_sum(cur_min), "partial sum");
            prev_min = cur_min;
         end
         if (turn_f) begin
            filt[idx_t'(nf)] = w1;
            if (n == 2) filt[idx_t'(nf + 1)] = w2;
            nf = nf + n;
         end else begin
            dat[idx_t'(nd)] = w1;
            if (n == 2) dat[idx_t'(nd + 1)] = w2;
            nd = nd + n;
         end
         turn_f = !turn_f;
      end
   endtask

   task automatic wait_result(input int hold_at, input int hold_len, input word_t exp);
      int   k;
      logic hold;
      logic got;
      k   = 0;
      got = 1'b0;
      while (!got) begin
         hold = (hold_len != 0) && (k >= hold_at) && (k < hold_at + hold_len);
         next_cycle(1'b1, hold);
         #SAMPLE_DLY;
         if (hold) begin
            check_flag(stall_o, 1'b0, "stall under hold");
            check_flag(result_valid_o, 1'b0, "valid under hold");
         end else if (result_valid_o) begin
            check_word(result_o, exp, "final sum");
            got = 1'b1;
         end
         k = k + 1;
      end
   endtask

   task automatic late_writes();
      for (int i = 0; i < 3; i++) begin
         next_cycle(1'b0, 1'b0);
         filter_wr2_i = (i == 0);
         data_wr2_i   = (i == 1);
         data_wr1_i   = (i == 2);
         rs1_i        = $random(seed);
         rs2_i        = $random(seed);
      end
   endtask

   task automatic run_case(input case_t tc);
      word_t exp;
      next_cycle(1'b0, 1'b0);
      filter_clr_i = tc.clr[0];
      data_clr_i   = tc.clr[1];
      if (tc.clr[1]) begin   // empty data bank answers at once with zero
         next_cycle(1'b1, 1'b0);
         #SAMPLE_DLY;
         check_flag(result_valid_o, 1'b1, "valid with empty data bank");
         check_word(result_o, '0, "sum after clear");
      end
      load_banks(tc.style, tc.run_early, tc.clr[0], tc.clr[1]);
      exp = partial_sum(ELEM_COUNT);
      wait_result(int'(tc.hold_at), int'(tc.hold_len), exp);
      if (tc.late_wr) begin
         late_writes();
         wait_result(0, 0, exp);
      end
   endtask

   initial begin
      rst_i        = 1'b0;
      hold_i       = 1'b0;
      filter_wr1_i = 1'b0;
      filter_wr2_i = 1'b0;
      filter_clr_i = 1'b0;
      data_wr1_i   = 1'b0;
      data_wr2_i   = 1'b0;
      data_clr_i   = 1'b0;
      conv_run_i   = 1'b0;
      rs1_i        = '0;
      rs2_i        = '0;
      repeat (4) @(negedge clk_i);
      rst_i = 1'b1;
      next_cycle(1'b0, 1'b0);
      next_cycle(1'b0, 1'b0);
      for (int c = 0; c < NUM_CASES; c++) begin
         run_case(cases[c]);
      end
      next_cycle(1'b0, 1'b0);
      if (dut_i.ctrl_i.asserts_i.fail_count != 0) begin
         $display("a handshake assertion failed, see the error above");
         $display("*** TEST FAILED ***");
         $fatal(1, "stopping after an assertion failure");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* design/conv_accel.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accel (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        hold_i,
   input  logic        filter_wr1_i,
   input  logic        filter_wr2_i,
   input  logic        filter_clr_i,
   input  logic        data_wr1_i,
   input  logic        data_wr2_i,
   input  logic        data_clr_i,
   input  logic        conv_run_i,
   input  logic [31:0] rs1_i,
   input  logic [31:0] rs2_i,
   output logic [31:0] result_o,
   output logic        result_valid_o,
   output logic        stall_o
);

   logic load;
   logic step;
   logic restart;   // either clear
   logic done;

   operand_rd_if rd_if ();

   operand_store store_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .hold_i       (hold_i),
      .done_i       (done),
      .filter_wr1_i (filter_wr1_i),
      .filter_wr2_i (filter_wr2_i),
      .filter_clr_i (filter_clr_i),
      .data_wr1_i   (data_wr1_i),
      .data_wr2_i   (data_wr2_i),
      .data_clr_i   (data_clr_i),
      .rs1_i        (rs1_i),
      .rs2_i        (rs2_i),
      .rd           (rd_if.store)
   );

   elem_counter counter_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .hold_i    (hold_i),
      .step_i    (step),
      .restart_i (restart),
      .rd        (rd_if.counter)
   );

   mac_unit mac_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .hold_i    (hold_i),
      .load_i    (load),
      .step_i    (step),
      .restart_i (restart),
      .rd        (rd_if.reader),
      .result_o  (result_o)
   );

   conv_ctrl ctrl_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .hold_i         (hold_i),
      .conv_run_i     (conv_run_i),
      .filter_clr_i   (filter_clr_i),
      .data_clr_i     (data_clr_i),
      .rd             (rd_if.reader),
      .load_o         (load),
      .step_o         (step),
      .restart_o      (restart),
      .done_o         (done),
      .stall_o        (stall_o),
      .result_valid_o (result_valid_o)
   );

endmodule

`default_nettype wire

/* design/conv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         hold_i,
   input  logic         conv_run_i,
   input  logic         filter_clr_i,
   input  logic         data_clr_i,
   operand_rd_if.reader rd,
   output logic         load_o,
   output logic         step_o,
   output logic         restart_o,
   output logic         done_o,
   output logic         stall_o,
   output logic         result_valid_o
);
   import conv_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   logic        pending;
   logic        last_idx;

   assign restart_o = filter_clr_i || data_clr_i;
   assign done_o    = (state_q == ST_DONE);
   assign last_idx  = (rd.idx == idx_t'(ELEM_COUNT - 1));

   // a clear in the same cycle wins over any datapath update
   assign load_o = !restart_o && (state_q == ST_WAIT) && rd.pair_present;
   assign step_o = !restart_o && (state_q == ST_ACC);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_WAIT: begin
            if (rd.pair_present)
               state_d = ST_ACC;   // product taken at this edge
         end
         ST_ACC: begin
            state_d = last_idx ? ST_DONE : ST_WAIT;
         end
         ST_DONE: begin
            state_d = ST_DONE;   // only a clear leaves
         end
         default: begin
            state_d = ST_WAIT;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= ST_WAIT;
      end else if (restart_o) begin
         state_q <= ST_WAIT;
      end else if (!hold_i) begin
         state_q <= state_d;
      end
   end

   // element in flight, or ready and about to be multiplied
   assign pending = (state_q == ST_ACC) || ((state_q == ST_WAIT) && rd.pair_present);

   // core handshake
   assign stall_o        = conv_run_i && !hold_i && !done_o && pending;
   assign result_valid_o = conv_run_i && !hold_i && !stall_o;

endmodule

`default_nettype wire

/* design/conv_pkg.sv */
`default_nettype none

package conv_pkg;

   localparam int ELEM_COUNT = 16;   // entries per bank
   localparam int WORD_W     = 32;
   localparam int IDX_W      = 4;

   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [IDX_W-1:0]    idx_t;
   typedef logic [2*WORD_W-1:0] prod_t;   // full multiplier output

   // controller sequence for one element: wait for the pair, then add
   typedef enum logic [1:0] {
      ST_WAIT = 2'd0,
      ST_ACC  = 2'd1,
      ST_DONE = 2'd2
   } ctrl_state_t;

endpackage

`default_nettype wire

/* design/elem_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module elem_counter (
   input  logic          clk_i,
   input  logic          rst_i,
   input  logic          hold_i,
   input  logic          step_i,
   input  logic          restart_i,
   operand_rd_if.counter rd
);
   import conv_pkg::*;

   idx_t idx_q;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         idx_q <= '0;
      end else if (restart_i) begin
         idx_q <= '0;
      end else if (step_i && !hold_i) begin
         idx_q <= idx_q + 1'b1;   // 15 -> 0
      end
   end

   assign rd.idx = idx_q;

endmodule

`default_nettype wire

/* design/mac_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             hold_i,
   input  logic             load_i,
   input  logic             step_i,
   input  logic             restart_i,
   operand_rd_if.reader     rd,
   output conv_pkg::word_t  result_o
);
   import conv_pkg::*;

   prod_t prod_q;
   word_t acc_q;

   // multiply stage, product kept until the add one cycle later
   always_ff @(posedge clk_i) begin
      if (load_i && !hold_i) begin
         prod_q <= prod_t'(rd.data_word) * prod_t'(rd.filter_word);
      end
   end

   // add stage, sum wraps modulo 2^32
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         acc_q <= '0;
      end else if (restart_i) begin
         acc_q <= '0;
      end else if (step_i && !hold_i) begin
         acc_q <= acc_q + prod_q[WORD_W-1:0];
      end
   end

   assign result_o = acc_q;

endmodule

`default_nettype wire

/* design/operand_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface operand_rd_if;
   import conv_pkg::*;

   idx_t  idx;            // current element index
   word_t data_word;
   word_t filter_word;
   logic  pair_present;   // both banks hold the entry at idx

   modport store (
      input  idx,
      output data_word,
      output filter_word,
      output pair_present
   );

   modport counter (
      output idx
   );

   modport reader (
      input idx,
      input data_word,
      input filter_word,
      input pair_present
   );

endinterface

`default_nettype wire

/* design/operand_store.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_store (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            hold_i,
   input  logic            done_i,
   input  logic            filter_wr1_i,
   input  logic            filter_wr2_i,
   input  logic            filter_clr_i,
   input  logic            data_wr1_i,
   input  logic            data_wr2_i,
   input  logic            data_clr_i,
   input  conv_pkg::word_t rs1_i,
   input  conv_pkg::word_t rs2_i,
   operand_rd_if.store     rd
);
   import conv_pkg::*;

   // bank 0 holds the filter, bank 1 the data
   word_t                 mem_q   [2][ELEM_COUNT];
   idx_t                  ptr_q   [2];
   idx_t                  ptr_inc [2];
   logic [ELEM_COUNT-1:0] mask_q  [2];   // presence flags

   logic [1:0] clr;
   logic [1:0] wr_en;
   logic [1:0] wr_pair;
   logic       wr_ok;

   assign clr     = {data_clr_i, filter_clr_i};
   assign wr_pair = {data_wr2_i, filter_wr2_i};
   assign wr_ok   = !hold_i && !done_i && !(|clr);

   // filter write wins when both banks are addressed in one cycle
   assign wr_en[0] = wr_ok && (filter_wr1_i || filter_wr2_i);
   assign wr_en[1] = wr_ok && !wr_en[0] && (data_wr1_i || data_wr2_i);

   always_comb begin
      for (int b = 0; b < 2; b++) begin
         ptr_inc[b] = ptr_q[b] + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int b = 0; b < 2; b++) begin
            ptr_q[b]  <= '0;
            mask_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < 2; b++) begin
            if (clr[b]) begin   // clear acts even under hold
               ptr_q[b]  <= '0;
               mask_q[b] <= '0;
            end else if (wr_en[b]) begin
               mask_q[b][ptr_q[b]] <= 1'b1;
               if (wr_pair[b]) begin
                  mask_q[b][ptr_inc[b]] <= 1'b1;
                  ptr_q[b]              <= ptr_q[b] + 2'd2;
               end else begin
                  ptr_q[b] <= ptr_inc[b];
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < 2; b++) begin
         if (wr_en[b]) begin
            mem_q[b][ptr_q[b]] <= rs1_i;
            if (wr_pair[b])
               mem_q[b][ptr_inc[b]] <= rs2_i;   // rs2 lands one above rs1
         end
      end
   end

   assign rd.filter_word  = mem_q[0][rd.idx];
   assign rd.data_word    = mem_q[1][rd.idx];
   assign rd.pair_present = mask_q[0][rd.idx] & mask_q[1][rd.idx];

endmodule

`default_nettype wire

/* verilog.f */
design/conv_pkg.sv
design/operand_rd_if.sv
design/operand_store.sv
design/elem_counter.sv
design/mac_unit.sv
design/conv_ctrl.sv
design/conv_accel.sv
bench/conv_accel_asserts.sv
bench/conv_accel_tb.sv
